//--- build.f
rtl/snow_pkg.sv
rtl/snow_tlb.sv
rtl/snow_cache_ctrl.sv
rtl/snow_fifo.sv
rtl/snow_mem_port.sv
rtl/snow_cache_top.sv
tests/snow_mem_model.sv
tests/snow_cache_tb.sv

//--- rtl/snow_cache_ctrl.sv
`timescale 1ns/1ps

module snow_cache_ctrl #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic               CPU_CLK,
  input  logic               RST,
  input  logic               cpu_req_stb,
  input  snow_pkg::cpu_req_t cpu_req,
  output logic               cpu_busy,
  output logic               cpu_rsp_stb,
  output snow_pkg::cpu_rsp_t cpu_rsp,
  input  logic [31:0]        paddr,
  input  logic               fault,
  output logic               req_push,
  output snow_pkg::mem_cmd_t req_data,
  input  logic               rsp_empty,
  input  snow_pkg::mem_rsp_t rsp_head,
  output logic               rsp_pop
);
  import snow_pkg::*;

  localparam int CW = $clog2(FIFO_DEPTH + 1);

  logic [31:0]   data_mem [256];
  logic [23:0]   tag_mem  [256];  // paddr[31:8]
  logic [255:0]  valid_q;

  cpu_req_t      req_q;           // request under compare
  logic          cmp_q;           // compare cycle
  logic [31:0]   data_rd_q;
  logic [23:0]   tag_rd_q;
  logic          valid_rd_q;

  logic          busy_q;
  logic          miss_pend_q;
  logic [31:0]   miss_addr_q;     // refill target
  logic [CW-1:0] credits_q;
  logic          rsp_stb_q;
  cpu_rsp_t      rsp_q;

  logic          hit;
  logic          wr_hit;
  logic          refill;
  logic          done;            // response goes out next cycle

  // ----------------------------------------
  // compare stage
  always_comb
  begin
    hit    = valid_rd_q && (tag_rd_q == paddr[31:8]);
    wr_hit = cmp_q && !fault && req_q.we && hit;

    req_push       = cmp_q && !fault && (req_q.we || !hit);  // writes and read misses
    req_data.addr  = paddr;
    req_data.we    = req_q.we;
    req_data.wdata = req_q.wdata;

    rsp_pop = !rsp_empty;                                  // drain every answer
    refill  = rsp_pop && !rsp_head.was_write && miss_pend_q;
    done    = (cmp_q && (fault || req_q.we || hit)) || refill;
  end

  assign cpu_busy    = busy_q || (credits_q == '0);
  assign cpu_rsp_stb = rsp_stb_q;
  assign cpu_rsp     = rsp_q;

  // ----------------------------------------
  // arrays and payload
  always_ff @(posedge CPU_CLK)
  begin
    if (cpu_req_stb)
    begin
      req_q      <= cpu_req;
      data_rd_q  <= data_mem[cpu_req.addr[7:0]];  // page offset, same before and after translation
      tag_rd_q   <= tag_mem[cpu_req.addr[7:0]];
      valid_rd_q <= valid_q[cpu_req.addr[7:0]];
    end

    if (refill)
    begin
      data_mem[miss_addr_q[7:0]] <= rsp_head.rdata;
      tag_mem[miss_addr_q[7:0]]  <= miss_addr_q[31:8];
    end
    else if (wr_hit)
      data_mem[paddr[7:0]] <= req_q.wdata;  // write-through, no allocate

    if (req_push && !req_q.we)
      miss_addr_q <= paddr;

    if (cmp_q)
    begin
      rsp_q.rdata <= (fault || req_q.we) ? '0 : data_rd_q;
      rsp_q.fault <= fault;
    end
    else if (refill)
    begin
      rsp_q.rdata <= rsp_head.rdata;
      rsp_q.fault <= 1'b0;
    end
  end

  // ----------------------------------------
  // control state
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      cmp_q       <= 1'b0;
      busy_q      <= 1'b0;
      miss_pend_q <= 1'b0;
      rsp_stb_q   <= 1'b0;
      valid_q     <= '0;
      credits_q   <= CW'(FIFO_DEPTH);
    end
    else
    begin
      cmp_q     <= cpu_req_stb;
      rsp_stb_q <= done;

      if (cpu_req_stb)
        busy_q <= 1'b1;
      else if (done)
        busy_q <= 1'b0;  // low together with the response strobe

      if (req_push && !req_q.we)
        miss_pend_q <= 1'b1;
      else if (refill)
        miss_pend_q <= 1'b0;

      if (refill)
        valid_q[miss_addr_q[7:0]] <= 1'b1;

      // one credit per outstanding memory command
      case ({req_push, rsp_pop})
        2'b10:   credits_q <= credits_q - 1'b1;
        2'b01:   credits_q <= credits_q + 1'b1;
        default: credits_q <= credits_q;
      endcase
    end
  end

endmodule

//--- rtl/snow_cache_top.sv
`timescale 1ns/1ps

module snow_cache_top #(
  parameter int FIFO_DEPTH = snow_pkg::FIFO_DEPTH_DFLT
) (
  input  logic               CPU_CLK,
  input  logic               RST,
  input  logic               cpu_req_stb,
  input  snow_pkg::cpu_req_t cpu_req,
  output logic               cpu_busy,
  output logic               cpu_rsp_stb,
  output snow_pkg::cpu_rsp_t cpu_rsp,
  input  logic               vmem_act,
  input  logic               tlb_wr_stb,
  input  snow_pkg::tlb_wr_t  tlb_wr,
  output logic               mem_cmd_stb,
  output snow_pkg::mem_cmd_t mem_cmd,
  input  logic               mem_ack,
  input  logic [31:0]        mem_rdata
);
  import snow_pkg::*;

  logic [31:0] paddr;
  logic        fault;

  logic        req_push;
  mem_cmd_t    req_data;
  logic        req_pop;
  mem_cmd_t    req_head;
  logic        req_empty;

  logic        rsp_push;
  mem_rsp_t    rsp_data;
  logic        rsp_pop;
  mem_rsp_t    rsp_head;
  logic        rsp_empty;

  snow_tlb i_snow_tlb (
    .CPU_CLK    (CPU_CLK),
    .RST        (RST),
    .lookup_stb (cpu_req_stb),
    .vaddr      (cpu_req.addr),
    .vmem_act   (vmem_act),
    .tlb_wr_stb (tlb_wr_stb),
    .tlb_wr     (tlb_wr),
    .paddr      (paddr),
    .fault      (fault)
  );

  snow_cache_ctrl #(.FIFO_DEPTH(FIFO_DEPTH)) i_snow_cache_ctrl (
    .CPU_CLK     (CPU_CLK),
    .RST         (RST),
    .cpu_req_stb (cpu_req_stb),
    .cpu_req     (cpu_req),
    .cpu_busy    (cpu_busy),
    .cpu_rsp_stb (cpu_rsp_stb),
    .cpu_rsp     (cpu_rsp),
    .paddr       (paddr),
    .fault       (fault),
    .req_push    (req_push),
    .req_data    (req_data),
    .rsp_empty   (rsp_empty),
    .rsp_head    (rsp_head),
    .rsp_pop     (rsp_pop)
  );

  // ----------------------------------------
  // buffering toward and from memory
  snow_fifo #(.T(mem_cmd_t), .DEPTH(FIFO_DEPTH)) req_fifo (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .push      (req_push),
    .push_data (req_data),
    .pop       (req_pop),
    .head      (req_head),
    .empty     (req_empty)
  );

  snow_fifo #(.T(mem_rsp_t), .DEPTH(FIFO_DEPTH)) rsp_fifo (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .push      (rsp_push),
    .push_data (rsp_data),
    .pop       (rsp_pop),
    .head      (rsp_head),
    .empty     (rsp_empty)
  );

  snow_mem_port i_snow_mem_port (
    .CPU_CLK     (CPU_CLK),
    .RST         (RST),
    .req_empty   (req_empty),
    .req_head    (req_head),
    .req_pop     (req_pop),
    .mem_cmd_stb (mem_cmd_stb),
    .mem_cmd     (mem_cmd),
    .mem_ack     (mem_ack),
    .mem_rdata   (mem_rdata),
    .rsp_push    (rsp_push),
    .rsp_data    (rsp_data)
  );

endmodule

//--- rtl/snow_fifo.sv
`timescale 1ns/1ps

module snow_fifo #(
  parameter type T     = logic [31:0],
  parameter int  DEPTH = 4
) (
  input  logic CPU_CLK,
  input  logic RST,
  input  logic push,
  input  T     push_data,
  input  logic pop,
  output T     head,
  output logic empty
);
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T              buf_mem [DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;

  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
    if (ptr == AW'(DEPTH - 1))
      return '0;  // wrap for any depth
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge CPU_CLK)
  begin
    if (push)
      buf_mem[wr_ptr_q] <= push_data;
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)
        rd_ptr_q <= ptr_inc(rd_ptr_q);

      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign head  = buf_mem[rd_ptr_q];  // always visible
  assign empty = (count_q == '0);

endmodule

//--- rtl/snow_mem_port.sv
`timescale 1ns/1ps

module snow_mem_port (
  input  logic               CPU_CLK,
  input  logic               RST,
  input  logic               req_empty,
  input  snow_pkg::mem_cmd_t req_head,
  output logic               req_pop,
  output logic               mem_cmd_stb,
  output snow_pkg::mem_cmd_t mem_cmd,
  input  logic               mem_ack,
  input  logic [31:0]        mem_rdata,
  output logic               rsp_push,
  output snow_pkg::mem_rsp_t rsp_data
);

  typedef enum logic {
    ST_IDLE,
    ST_WAIT
  } state_t;

  state_t state_q;
  logic   ack_seen;

  assign req_pop  = (state_q == ST_IDLE) && !req_empty;  // take the head
  assign ack_seen = (state_q == ST_WAIT) && mem_ack;

  // ----------------------------------------
  // sequencer
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state_q     <= ST_IDLE;
      mem_cmd_stb <= 1'b0;
      rsp_push    <= 1'b0;
    end
    else
    begin
      mem_cmd_stb <= req_pop;   // one pulse per command
      rsp_push    <= ack_seen;

      case (state_q)
        ST_IDLE:
          if (req_pop)
            state_q <= ST_WAIT;
        ST_WAIT:
          if (mem_ack)
            state_q <= ST_IDLE;
        default:
          state_q <= ST_IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // command and answer payload
  always_ff @(posedge CPU_CLK)
  begin
    if (req_pop)
      mem_cmd <= req_head;

    if (ack_seen)
    begin
      rsp_data.rdata     <= mem_rdata;  // valid with the ack on reads
      rsp_data.was_write <= mem_cmd.we;
    end
  end

endmodule

//--- rtl/snow_pkg.sv
package snow_pkg;

  // ----------------------------------------
  // sizing
  localparam int FIFO_DEPTH_DFLT = 4;  // request/response FIFO entries

  // ----------------------------------------
  // CPU side
  typedef struct packed {
    logic [31:0] addr;   // virtual address
    logic        we;     // 1 = write
    logic [31:0] wdata;
  } cpu_req_t;

  typedef struct packed {
    logic [31:0] rdata;  // zero on writes and faults
    logic        fault;  // vtag mismatch
  } cpu_rsp_t;

  // ----------------------------------------
  // translation
  typedef struct packed {
    logic [15:0] vtag;   // compared against vaddr[31:16]
    logic [15:0] ptag;   // replaces vaddr[31:16]
  } tlb_entry_t;

  typedef struct packed {
    logic [7:0] idx;     // entry slot, vaddr[15:8]
    tlb_entry_t entry;
  } tlb_wr_t;

  // ----------------------------------------
  // memory side, also the FIFO payloads
  typedef struct packed {
    logic [31:0] addr;   // physical address
    logic        we;
    logic [31:0] wdata;
  } mem_cmd_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        was_write;  // write answers only return a credit
  } mem_rsp_t;

endpackage

//--- rtl/snow_tlb.sv
`timescale 1ns/1ps

module snow_tlb (
  input  logic              CPU_CLK,
  input  logic              RST,
  input  logic              lookup_stb,
  input  logic [31:0]       vaddr,
  input  logic              vmem_act,
  input  logic              tlb_wr_stb,
  input  snow_pkg::tlb_wr_t tlb_wr,
  output logic [31:0]       paddr,
  output logic              fault
);
  import snow_pkg::*;

  tlb_entry_t  tlb_mem [256];  // indexed by vaddr[15:8]
  tlb_entry_t  entry_q;        // entry read in the request cycle
  logic [31:0] vaddr_q;
  logic        vmem_q;

  // ----------------------------------------
  // entry storage and lookup read
  always_ff @(posedge CPU_CLK)
  begin
    if (tlb_wr_stb)
      tlb_mem[tlb_wr.idx] <= tlb_wr.entry;  // load from outside

    if (lookup_stb)
    begin
      entry_q <= tlb_mem[vaddr[15:8]];
      vaddr_q <= vaddr;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
      vmem_q <= 1'b0;
    else if (lookup_stb)
      vmem_q <= vmem_act;  // translation mode of this request
  end

  // ----------------------------------------
  // translation, valid in the compare cycle
  always_comb
  begin
    if (vmem_q)
      paddr = {entry_q.ptag, vaddr_q[15:0]};
    else
      paddr = vaddr_q;  // identity mapping

    fault = vmem_q && (entry_q.vtag != vaddr_q[31:16]);
  end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module snow_cache_tb -f build.f -o snow_cache_sim

out=$(./obj_dir/snow_cache_sim) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'RESULT: PASS'

//--- tests/snow_cache_patterns.txt
# op vmem addr_or_tlb_idx data_or_tlb_entry exp_rdata exp_fault
# ops: R read, W write, B burst write, T TLB load with entry {vtag, ptag}
R 0 00001234 00000000 ffffedcb 0
R 0 00001234 00000000 ffffedcb 0
W 0 00001234 cafef00d 00000000 0
R 0 00001234 00000000 cafef00d 0
W 0 00002040 12345678 00000000 0
R 0 00002040 00000000 12345678 0
R 0 00005034 00000000 ffffafcb 0
R 0 00001234 00000000 cafef00d 0
T 0 00000012 a5a50007 00000000 0
R 1 a5a512f0 00000000 fff8ed0f 0
R 1 a5a512f0 00000000 fff8ed0f 0
R 0 000712f0 00000000 fff8ed0f 0
T 0 00000030 00010002 00000000 0
R 1 00013004 00000000 fffdcffb 0
W 1 00013008 0badcafe 00000000 0
R 0 00023008 00000000 0badcafe 0
R 1 5a5a1200 00000000 00000000 1
W 1 5a5a1234 deadbeef 00000000 1
R 1 00013004 00000000 fffdcffb 0
R 0 00004001 00000000 ffffbffe 0
B 0 00004000 a0000000 00000000 0
B 0 00004001 a0000001 00000000 0
B 0 00004002 a0000002 00000000 0
B 0 00004003 a0000003 00000000 0
B 0 00004000 a0000004 00000000 0
B 0 00004001 a0000005 00000000 0
B 0 00004002 a0000006 00000000 0
B 0 00004003 a0000007 00000000 0
R 0 00004000 00000000 a0000004 0
R 0 00004001 00000000 a0000005 0
R 0 00004002 00000000 a0000006 0
R 0 00004003 00000000 a0000007 0

//--- tests/snow_cache_tb.sv
`timescale 1ns/1ps

module snow_cache_tb;
  import snow_pkg::*;

  localparam int    CLK_PERIOD    = 40;
  localparam int    RESET_CYCLES  = 16;
  localparam int    CYCLES_PER_OP = 40;
  localparam string PATTERN_FILE  = "tests/snow_cache_patterns.txt";

  typedef struct packed {
    logic [7:0]  op;    // R, W, B or T
    logic        vmem;
    logic [31:0] addr;  // TLB index for T
    logic [31:0] data;  // TLB entry for T
    cpu_rsp_t    exp;
  } pattern_t;

  logic        CPU_CLK;
  logic        RST;
  logic        cpu_req_stb;
  cpu_req_t    cpu_req;
  logic        cpu_busy;
  logic        cpu_rsp_stb;
  cpu_rsp_t    cpu_rsp;
  logic        vmem_act;
  logic        tlb_wr_stb;
  tlb_wr_t     tlb_wr;
  logic        mem_cmd_stb;
  mem_cmd_t    mem_cmd;
  logic        mem_ack;
  logic [31:0] mem_rdata;
  int          cmd_count;

  pattern_t    ops [$];
  bit          loaded;
  tlb_entry_t  ref_tlb   [256];  // reference translation state
  bit          ref_valid [256];
  logic [23:0] ref_tag   [256];
  mem_cmd_t    exp_cmds [$];     // expected command stream
  int          cmds_checked;

  snow_cache_top #(.FIFO_DEPTH(4)) i_snow_cache_top (
    .CPU_CLK     (CPU_CLK),
    .RST         (RST),
    .cpu_req_stb (cpu_req_stb),
    .cpu_req     (cpu_req),
    .cpu_busy    (cpu_busy),
    .cpu_rsp_stb (cpu_rsp_stb),
    .cpu_rsp     (cpu_rsp),
    .vmem_act    (vmem_act),
    .tlb_wr_stb  (tlb_wr_stb),
    .tlb_wr      (tlb_wr),
    .mem_cmd_stb (mem_cmd_stb),
    .mem_cmd     (mem_cmd),
    .mem_ack     (mem_ack),
    .mem_rdata   (mem_rdata)
  );

  snow_mem_model i_snow_mem_model (
    .CPU_CLK     (CPU_CLK),
    .RST         (RST),
    .mem_cmd_stb (mem_cmd_stb),
    .mem_cmd     (mem_cmd),
    .mem_ack     (mem_ack),
    .mem_rdata   (mem_rdata),
    .cmd_count   (cmd_count)
  );

  initial
  begin
    CPU_CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CPU_CLK = ~CPU_CLK;
  end

  // ----------------------------------------
  // failure reporting and compares
  task automatic stop_failed();
    $display("RESULT: FAIL");
    $fatal(1, "testbench stopped at the first failure");
  endtask

  task automatic check_rsp(input string name, input cpu_rsp_t exp, input cpu_rsp_t act);
    if (act !== exp)
    begin
      $display("** Error: %s: expected rdata %h fault %b, actual rdata %h fault %b",
               name, exp.rdata, exp.fault, act.rdata, act.fault);
      stop_failed();
    end
  endtask

  task automatic check_cmd(input string name, input mem_cmd_t exp, input mem_cmd_t act);
    if (act !== exp)
    begin
      $display("** Error: %s: expected addr %h we %b wdata %h, actual addr %h we %b wdata %h",
               name, exp.addr, exp.we, exp.wdata, act.addr, act.we, act.wdata);
      stop_failed();
    end
  endtask

  // ----------------------------------------
  // pattern file
  task automatic load_patterns();
    int          fd;
    int          n;
    int          vmem_i;
    int          fault_i;
    string       line;
    string       rest;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] r;
    pattern_t    p;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0)
    begin
      $display("cannot open the pattern file %s", PATTERN_FILE);
      stop_failed();
    end
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() < 2 || line.getc(0) == "#")
        continue;  // blank or column notes
      rest = line.substr(2, line.len() - 1);
      n = $sscanf(rest, "%d %h %h %h %d", vmem_i, a, d, r, fault_i);
      if (n != 5)
      begin
        $display("malformed pattern line: %s", line);
        stop_failed();
      end
      p.op        = line.getc(0);
      p.vmem      = vmem_i[0];
      p.addr      = a;
      p.data      = d;
      p.exp.rdata = r;
      p.exp.fault = fault_i[0];
      ops.push_back(p);
    end
    $fclose(fd);
  endtask

  // ----------------------------------------
  // reference for commands that reach memory
  function automatic void expect_cmds(input pattern_t p);
    tlb_entry_t  e;
    logic [31:0] pa;
    mem_cmd_t    c;
    e = ref_tlb[p.addr[15:8]];
    if (p.vmem && e.vtag != p.addr[31:16])
      return;  // faults stay inside the cache
    pa = p.vmem ? {e.ptag, p.addr[15:0]} : p.addr;
    c.addr  = pa;
    c.we    = (p.op != "R");
    c.wdata = p.data;
    if (!c.we)
    begin
      if (ref_valid[pa[7:0]] && ref_tag[pa[7:0]] == pa[31:8])
        return;  // read hit
      ref_valid[pa[7:0]] = 1'b1;
      ref_tag[pa[7:0]]   = pa[31:8];
    end
    exp_cmds.push_back(c);
  endfunction

  task automatic write_tlb(input pattern_t p);
    while (cpu_busy)
      @(negedge CPU_CLK);
    tlb_wr_stb   = 1'b1;
    tlb_wr.idx   = p.addr[7:0];
    tlb_wr.entry = p.data;
    @(negedge CPU_CLK);
    tlb_wr_stb = 1'b0;
    ref_tlb[p.addr[7:0]] = p.data;
  endtask

  task automatic run_access(input string name, input pattern_t p);
    cpu_rsp_t got;
    while (cpu_busy)
      @(negedge CPU_CLK);
    cpu_req_stb   = 1'b1;
    cpu_req.addr  = p.addr;
    cpu_req.we    = (p.op != "R");
    cpu_req.wdata = p.data;
    vmem_act      = p.vmem;
    @(negedge CPU_CLK);
    cpu_req_stb = 1'b0;
    do
    begin
      if (!cpu_busy)
      begin
        $display("cpu_busy dropped during %s before its response arrived", name);
        stop_failed();
      end
      @(negedge CPU_CLK);
    end
    while (!cpu_rsp_stb);
    got = cpu_rsp;
    check_rsp(name, p.exp, got);
  endtask

  // waits until every expected command was issued, then checks them in order
  task automatic drain_cmd_log(input string name);
    mem_cmd_t got;
    while (cmd_count < exp_cmds.size())
      @(negedge CPU_CLK);
    if (cmd_count > exp_cmds.size())
    begin
      $display("unexpected memory command during %s: %0d issued but %0d expected",
               name, cmd_count, exp_cmds.size());
      stop_failed();
    end
    while (cmds_checked < cmd_count)
    begin
      got = i_snow_mem_model.cmd_log[cmds_checked];
      check_cmd($sformatf("%s, command %0d", name, cmds_checked + 1),
                exp_cmds[cmds_checked], got);
      cmds_checked++;
    end
  endtask

  // ----------------------------------------
  // main sequence
  initial
  begin
    int       i;
    string    name;
    pattern_t p;
    RST          = 1'b0;
    cpu_req_stb  = 1'b0;
    cpu_req      = '0;
    vmem_act     = 1'b0;
    tlb_wr_stb   = 1'b0;
    tlb_wr       = '0;
    cmds_checked = 0;
    load_patterns();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(negedge CPU_CLK);
    RST = 1'b1;
    @(negedge CPU_CLK);
    for (i = 0; i < ops.size(); i++)
    begin
      p    = ops[i];
      name = $sformatf("op %0d (%c)", i + 1, p.op);
      case (p.op)
        "T":
          write_tlb(p);
        "R", "W", "B":
        begin
          expect_cmds(p);
          run_access(name, p);
        end
        default:
        begin
          $display("unknown operation %c in %s", p.op, name);
          stop_failed();
        end
      endcase
      if (p.op != "B")
        drain_cmd_log(name);  // bursts stay queued
    end
    drain_cmd_log("final drain");
    $display("RESULT: PASS");
    $finish;
  end

  // watchdog sized from the pattern count
  initial
  begin
    longint limit_ns;
    wait (loaded);
    limit_ns = longint'(ops.size()) * CYCLES_PER_OP * CLK_PERIOD;
    #(limit_ns);
    $display("watchdog expired after %0d ns: no response arrived from the DUT", limit_ns);
    stop_failed();
  end

endmodule

//--- tests/snow_mem_model.sv
`timescale 1ns/1ps

module snow_mem_model #(
  parameter int LOG_SIZE = 64
) (
  input  logic               CPU_CLK,
  input  logic               RST,
  input  logic               mem_cmd_stb,
  input  snow_pkg::mem_cmd_t mem_cmd,
  output logic               mem_ack,
  output logic [31:0]        mem_rdata,
  output int                 cmd_count
);
  import snow_pkg::*;

  logic [31:0] store [logic [31:0]];  // only words that were written
  mem_cmd_t    cmd_log [LOG_SIZE];    // every command in issue order
  mem_cmd_t    cur_q;
  logic        busy_q  = 1'b0;
  int          wait_q  = 0;
  logic        ack_q   = 1'b0;
  logic [31:0] rdata_q = '0;
  int          count_q = 0;

  assign mem_ack   = ack_q;
  assign mem_rdata = rdata_q;
  assign cmd_count = count_q;

  initial
  begin
    void'($urandom(16));  // single seed for the run
  end

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (store.exists(addr))
      return store[addr];
    return ~addr;  // unwritten word
  endfunction

  // ----------------------------------------
  // one command at a time, random latency
  always @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      busy_q  <= 1'b0;
      ack_q   <= 1'b0;
      wait_q  <= 0;
      count_q <= 0;
    end
    else
    begin
      ack_q <= 1'b0;
      if (mem_cmd_stb && !busy_q)
      begin
        cur_q  <= mem_cmd;
        busy_q <= 1'b1;
        wait_q <= 1 + int'($urandom % 8);  // 1 to 8 cycles
        if (count_q < LOG_SIZE)
          cmd_log[count_q] <= mem_cmd;
        count_q <= count_q + 1;
      end
      else if (busy_q)
      begin
        if (wait_q <= 1)
        begin
          ack_q  <= 1'b1;
          busy_q <= 1'b0;
          if (cur_q.we)
          begin
            store[cur_q.addr] = cur_q.wdata;  // applied in issue order
            rdata_q <= '0;
          end
          else
            rdata_q <= read_word(cur_q.addr);
        end
        wait_q <= wait_q - 1;
      end
    end
  end

endmodule
